// ==== filelist.f ====
source/enc_pkg.sv
source/enc_code6_mux.sv
source/enc_code4_mux.sv
source/enc_disparity_ctrl.sv
source/enc_tx_top.sv
sim/enc_tx_sva.sv
sim/enc_tx_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the encoder testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module enc_tx_tb \
   -f filelist.f \
   -o enc_tx_sim \
   || { echo "Verilator build failed"; exit 1; }

output=$(./obj_dir/enc_tx_sim +verilator+error+limit+10 2>&1)
echo "$output"

echo "$output" | grep -q 'All tests passed!' && exit 0 || exit 1

// ==== sim/enc_tx_tb.sv ====
// ----------------------------------------
// Testbench for the 8b/10b transmit encoder,
// drives characters while bound checks run
// ----------------------------------------
module enc_tx_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import enc_pkg::*;

   localparam int CLK_PERIOD      = 10;
   localparam int RESET_CYCLES    = 2;
   localparam int DIRECTED_LEN    = 20;
   localparam int RANDOM_LEN      = 400;
   localparam int INVALID_LEN     = 6;
   localparam int MARGIN          = 50;
   localparam int WATCHDOG_CYCLES = RESET_CYCLES + DIRECTED_LEN + RANDOM_LEN +
                                    INVALID_LEN + ENC_LATENCY + MARGIN;

   logic        CLK;
   logic        aresetn;
   tx_char_t    tx_in;
   code10_t     tx_code;
   logic        code_err;
   rd_t         rd;
   logic [31:0] seed;
   logic        sva_failed;

   enc_tx_top enc_tx_top_inst (
      .CLK      (CLK),
      .aresetn  (aresetn),
      .tx_in    (tx_in),
      .tx_code  (tx_code),
      .code_err (code_err),
      .rd       (rd)
   );

   assign sva_failed = enc_tx_top_inst.enc_tx_sva_inst.failed;

   initial
   begin
      CLK = 1'b0;
   end

   always #(CLK_PERIOD / 2) CLK = ~CLK;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // K28.0 to K28.7, then K23.7, K27.7, K29.7, K30.7
   function automatic tx_char_t valid_k_char(input int idx);
      case (idx)
         0:       return 9'h11C;
         1:       return 9'h13C;
         2:       return 9'h15C;
         3:       return 9'h17C;
         4:       return 9'h19C;
         5:       return 9'h1BC;
         6:       return 9'h1DC;
         7:       return 9'h1FC;
         8:       return 9'h1F7;
         9:       return 9'h1FB;
         10:      return 9'h1FD;
         default: return 9'h1FE;
      endcase
   endfunction

   // K28.5 twice so both disparities occur, D17.7 takes the A7 form
   function automatic tx_char_t directed_char(input int idx);
      case (idx)
         0:       return 9'h000;
         1:       return 9'h1BC;
         2:       return 9'h1BC;
         3:       return 9'h0B5;
         4:       return 9'h0E7;
         5:       return 9'h0E7;
         6:       return 9'h0F1;
         7:       return 9'h0B5;
         default: return valid_k_char(idx - 8);
      endcase
   endfunction

   // K0.0, K21.5, K23.0, K7.7, K27.0, then one data byte
   function automatic tx_char_t invalid_char(input int idx);
      case (idx)
         0:       return 9'h100;
         1:       return 9'h1B5;
         2:       return 9'h117;
         3:       return 9'h1E7;
         4:       return 9'h11B;
         default: return 9'h0B5;
      endcase
   endfunction

   // Mostly data, about one in sixteen is a legal control character
   function automatic tx_char_t random_char(input logic [31:0] r);
      tx_char_t c;
      if (r[11:8] == 4'd0)
      begin
         c = valid_k_char(int'(r[15:12]) % 12);
      end
      else
      begin
         c = {1'b0, r[7:0]};
      end
      return c;
   endfunction

   task automatic send_char(input tx_char_t c);
      tx_in = c;
      @(negedge CLK);
   endtask

   always @(negedge CLK)
   begin
      if (sva_failed)
      begin
         $display("Test failures found");
         $fatal(1, "Stopped at the first failed assertion");
      end
   end

   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Run timed out before the stimulus finished");
      $display("Test failures found");
      $fatal(1, "Watchdog expired");
   end

   initial
   begin
      int i;
      aresetn = 1'b0;
      tx_in   = '0;
      seed    = 32'h134ed3b7;
      repeat (RESET_CYCLES) @(negedge CLK);
      aresetn = 1'b1;

      for (i = 0; i < DIRECTED_LEN; i++)
      begin
         send_char(directed_char(i));
      end
      for (i = 0; i < RANDOM_LEN; i++)
      begin
         seed = xorshift32(seed);
         send_char(random_char(seed));
      end
      for (i = 0; i < INVALID_LEN; i++)
      begin
         send_char(invalid_char(i));
      end

      // Flush the three-stage pipeline with data
      repeat (ENC_LATENCY + 1) send_char(9'h0B5);
      #1;

      if (sva_failed)
      begin
         $display("Test failures found");
         $fatal(1, "Assertion failure detected at end of run");
      end
      else
      begin
         $display("All tests passed!");
         $finish;
      end
   end

endmodule

// ==== sim/enc_tx_sva.sv ====
// ----------------------------------------
// Concurrent checks on the encoder outputs,
// bound into enc_tx_top for simulation
// ----------------------------------------
module enc_tx_sva (
   input logic              CLK,
   input logic              aresetn,
   input enc_pkg::tx_char_t tx_in,
   input enc_pkg::code10_t  tx_code,
   input logic              code_err,
   input enc_pkg::rd_t      rd
);
   timeunit 1ns;
   timeprecision 1ps;
   import enc_pkg::*;

   int          run_cnt;
   tx_char_t    hist1;
   tx_char_t    hist2;
   tx_char_t    hist3;
   rd_t         rd_prev;
   code10_t     code_prev;
   logic        err_prev;
   logic        chk;
   logic        pair_chk;
   int          ones;
   int          run_max;
   rd_t         exp_rd;
   logic [10:0] known;
   bit          fail_reset = 1'b0;
   bit          fail_balance = 1'b0;
   bit          fail_rd = 1'b0;
   bit          fail_known = 1'b0;
   bit          fail_err = 1'b0;
   bit          fail_run = 1'b0;
   logic        failed;

   // K28.x, K23.7, K27.7, K29.7 and K30.7 are the legal control characters
   function automatic logic k_invalid(input tx_char_t c);
      logic k7_legal;
      k7_legal = (c.data[7:5] == 3'd7) &&
                 ((c.data[4:0] == 5'd23) || (c.data[4:0] == 5'd27) ||
                  (c.data[4:0] == 5'd29) || (c.data[4:0] == 5'd30));
      return c.k && (c.data[4:0] != 5'd28) && !k7_legal;
   endfunction

   // Hit flag and expected abcdeifghj from the standard code table
   function automatic logic [10:0] known_vector(input tx_char_t c, input rd_t r);
      logic [10:0] v;
      v = '0;
      case (c)
         9'h1BC: v = (r == RD_NEG) ? {1'b1, 10'b0011111010} : {1'b1, 10'b1100000101};
         9'h0B5: v = {1'b1, 10'b1010101010};
         9'h000: v = (r == RD_NEG) ? {1'b1, 10'b1001110100} : 11'd0;
         9'h0E7: v = (r == RD_NEG) ? {1'b1, 10'b1110001110} : {1'b1, 10'b0001110001};
         9'h0F1: v = (r == RD_NEG) ? {1'b1, 10'b1000110111} : 11'd0;
         default: v = '0;
      endcase
      return v;
   endfunction

   function automatic int longest_run(input logic [19:0] bits);
      int best;
      int cur;
      int i;
      best = 1;
      cur  = 1;
      for (i = 1; i < 20; i++)
      begin
         cur  = (bits[i] == bits[i-1]) ? cur + 1 : 1;
         best = (cur > best) ? cur : best;
      end
      return best;
   endfunction

   // Input history lined up with the output, plus the previous group
   always_ff @(posedge CLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         run_cnt   <= 0;
         hist1     <= '0;
         hist2     <= '0;
         hist3     <= '0;
         rd_prev   <= RD_NEG;
         code_prev <= '0;
         err_prev  <= 1'b0;
      end
      else
      begin
         run_cnt   <= (run_cnt < 4) ? run_cnt + 1 : run_cnt;
         hist1     <= tx_in;
         hist2     <= hist1;
         hist3     <= hist2;
         rd_prev   <= rd;
         code_prev <= tx_code;
         err_prev  <= code_err;
      end
   end

   assign chk      = (run_cnt >= ENC_LATENCY);
   assign pair_chk = (run_cnt == 4) && !code_err && !err_prev;
   assign ones     = $countones(tx_code);
   assign run_max  = longest_run({code_prev, tx_code});
   assign known    = known_vector(hist3, rd_prev);
   assign failed   = fail_reset | fail_balance | fail_rd | fail_known | fail_err | fail_run;

   always_comb
   begin
      if (ones == 6)
      begin
         exp_rd = RD_POS;
      end
      else if (ones == 4)
      begin
         exp_rd = RD_NEG;
      end
      else
      begin
         exp_rd = rd_prev;
      end
   end

   // Zeroed selects encode as D0.0 and reach tx_code one edge before the first input
   a_reset_state: assert property (@(posedge CLK)
      (run_cnt < ENC_LATENCY - 1) |-> ((tx_code == '0) && !code_err && (rd == RD_NEG)))
      else
      begin
         fail_reset = 1'b1;
         $error("Mismatch reset_state: expected 0/0/0 actual %b/%b/%0d", tx_code, code_err, rd);
      end

   a_word_balance: assert property (@(posedge CLK) disable iff (!aresetn)
      chk |-> ((ones == 5) || ((ones == 6) && (rd_prev == RD_NEG)) ||
               ((ones == 4) && (rd_prev == RD_POS))))
      else
      begin
         fail_balance = 1'b1;
         $error("Mismatch word_balance: expected 4/5/6 ones for rd %0d actual %0d ones",
                rd_prev, ones);
      end

   a_rd_tracking: assert property (@(posedge CLK) disable iff (!aresetn)
      chk |-> (rd == exp_rd))
      else
      begin
         fail_rd = 1'b1;
         $error("Mismatch rd_tracking: expected %0d actual %0d", exp_rd, rd);
      end

   a_known_vector: assert property (@(posedge CLK) disable iff (!aresetn)
      (chk && known[10]) |-> (tx_code == known[9:0]))
      else
      begin
         fail_known = 1'b1;
         $error("Mismatch known_vector %h: expected %b actual %b", hist3, known[9:0], tx_code);
      end

   a_error_flag: assert property (@(posedge CLK) disable iff (!aresetn)
      chk |-> (code_err == k_invalid(hist3)))
      else
      begin
         fail_err = 1'b1;
         $error("Mismatch error_flag %h: expected %b actual %b",
                hist3, k_invalid(hist3), code_err);
      end

   a_run_length: assert property (@(posedge CLK) disable iff (!aresetn)
      pair_chk |-> (run_max <= 5))
      else
      begin
         fail_run = 1'b1;
         $error("Mismatch run_length: expected at most 5 actual %0d", run_max);
      end

endmodule

bind enc_tx_top enc_tx_sva enc_tx_sva_inst (
   .CLK      (CLK),
   .aresetn  (aresetn),
   .tx_in    (tx_in),
   .tx_code  (tx_code),
   .code_err (code_err),
   .rd       (rd)
);

// ==== source/enc_tx_top.sv ====
// --------------------------------------
// 8b/10b transmit encoder top, one character in
// and one code group out per clock
// --------------------------------------
module enc_tx_top (
   input  logic              CLK,
   input  logic              aresetn,
   input  enc_pkg::tx_char_t tx_in,
   output enc_pkg::code10_t  tx_code,
   output logic              code_err,
   output enc_pkg::rd_t      rd
);
   import enc_pkg::*;

   sel5_t      sel5;
   sel3_t      sel3;
   logic [5:0] sub6;
   logic [3:0] sub4;

   // Split HGF and EDCBA, k goes with both halves
   assign sel5.k     = tx_in.k;
   assign sel5.edcba = tx_in.data[4:0];
   assign sel3.k     = tx_in.k;
   assign sel3.hgf   = tx_in.data[7:5];

   // Both selectors take two cycles, so sub6 and sub4 stay aligned
   enc_code6_mux enc_code6_mux_inst (
      .CLK     (CLK),
      .aresetn (aresetn),
      .sel     (sel5),
      .sub6    (sub6)
   );

   enc_code4_mux enc_code4_mux_inst (
      .CLK     (CLK),
      .aresetn (aresetn),
      .sel     (sel3),
      .sub4    (sub4)
   );

   // Validity check runs on the raw input and is delayed inside
   enc_disparity_ctrl enc_disparity_ctrl_inst (
      .CLK      (CLK),
      .aresetn  (aresetn),
      .k        (tx_in.k),
      .sel5     (sel5),
      .sel3     (sel3),
      .sub6     (sub6),
      .sub4     (sub4),
      .tx_code  (tx_code),
      .code_err (code_err),
      .rd       (rd)
   );

endmodule

// ==== source/enc_disparity_ctrl.sv ====
// --------------------------------------
// Running disparity control, final code group
// and control character check, one output stage
// --------------------------------------
module enc_disparity_ctrl (
   input  logic             CLK,
   input  logic             aresetn,
   input  logic             k,
   input  enc_pkg::sel5_t   sel5,
   input  enc_pkg::sel3_t   sel3,
   input  logic [5:0]       sub6,
   input  logic [3:0]       sub4,
   output enc_pkg::code10_t tx_code,
   output logic             code_err,
   output enc_pkg::rd_t     rd
);
   import enc_pkg::*;

   logic       k7_ok;
   logic       k_bad;
   logic       hgf7;
   logic       k_d1;
   logic       k_d2;
   logic       err_d1;
   logic       err_d2;
   logic       hgf7_d1;
   logic       hgf7_d2;
   logic       flip6;
   logic       use_a7;
   logic       flip4;
   logic [5:0] code6;
   logic [3:0] code4_sel;
   logic [3:0] code4;
   rd_t        rd_mid;
   rd_t        rd_next;

   // Valid K set: K28.x plus K23.7, K27.7, K29.7, K30.7
   assign k7_ok = (sel3.hgf == HGF_7) &&
                  (sel5.edcba inside {5'd23, 5'd27, 5'd29, 5'd30});
   assign k_bad = k && !((sel5.edcba == K28_IDX) || k7_ok);
   assign hgf7  = (sel3.hgf == HGF_7);

   // Two stages to line up with sub6 and sub4
   always_ff @(posedge CLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         k_d1    <= 1'b0;
         k_d2    <= 1'b0;
         err_d1  <= 1'b0;
         err_d2  <= 1'b0;
         hgf7_d1 <= 1'b0;
         hgf7_d2 <= 1'b0;
      end
      else
      begin
         k_d1    <= k;
         k_d2    <= k_d1;
         err_d1  <= k_bad;
         err_d2  <= err_d1;
         hgf7_d1 <= hgf7;
         hgf7_d2 <= hgf7_d1;
      end
   end

   always_comb
   begin
      // 6b side, D.7 is balanced but still alternates
      flip6 = (rd == RD_POS) && (($countones(sub6) != 3) || (sub6 == CODE6_D7));
      code6 = flip6 ? ~sub6 : sub6;

      if ($countones(code6) == 4)
      begin
         rd_mid = RD_POS;
      end
      else if ($countones(code6) == 2)
      begin
         rd_mid = RD_NEG;
      end
      else
      begin
         rd_mid = rd;
      end

      // A7 avoids a run of five across the e-i / f-g boundary
      use_a7 = !k_d2 && hgf7_d2 &&
               (((rd_mid == RD_NEG) && (code6[1:0] == 2'b11)) ||
                ((rd_mid == RD_POS) && (code6[1:0] == 2'b00)));
      code4_sel = use_a7 ? CODE4_A7 : sub4;

      flip4 = (rd_mid == RD_POS) &&
              (k_d2 || ($countones(code4_sel) != 2) || (code4_sel == CODE4_D3));
      code4 = flip4 ? ~code4_sel : code4_sel;

      // More ones than zeros leaves the line positive
      if ($countones(code4) == 3)
      begin
         rd_next = RD_POS;
      end
      else if ($countones(code4) == 1)
      begin
         rd_next = RD_NEG;
      end
      else
      begin
         rd_next = rd_mid;
      end
   end

   // Output stage, third of ENC_LATENCY
   always_ff @(posedge CLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         tx_code  <= '0;
         code_err <= 1'b0;
         rd       <= RD_NEG;
      end
      else
      begin
         tx_code.code6 <= code6;
         tx_code.code4 <= code4;
         code_err      <= err_d2;
         rd            <= rd_next;
      end
   end

endmodule

// ==== source/enc_code4_mux.sv ====
// --------------------------------------
// 3b/4b sub-block selector, data or control
// table by k, same two stages as the 6b side
// --------------------------------------
module enc_code4_mux (
   input  logic           CLK,
   input  logic           aresetn,
   input  enc_pkg::sel3_t sel,
   output logic [3:0]     sub4
);
   import enc_pkg::*;

   sel3_t      sel_r;
   logic [3:0] code4;

   always_ff @(posedge CLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         sel_r <= '0;
         sub4  <= '0;
      end
      else
      begin
         sel_r <= sel;
         sub4  <= code4;
      end
   end

   // fghj, RD-minus forms before any complement
   always_comb
   begin
      if (sel_r.k)
      begin
         case (sel_r.hgf)
            3'd0:    code4 = 4'b1011;
            3'd1:    code4 = 4'b0110;
            3'd2:    code4 = 4'b1010;
            3'd3:    code4 = 4'b1100;
            3'd4:    code4 = 4'b1101;
            3'd5:    code4 = 4'b0101;
            3'd6:    code4 = 4'b1001;
            default: code4 = 4'b0111;
         endcase
      end
      else
      begin
         case (sel_r.hgf)
            3'd0:    code4 = 4'b1011;
            3'd1:    code4 = 4'b1001;
            3'd2:    code4 = 4'b0101;
            3'd3:    code4 = 4'b1100;
            3'd4:    code4 = 4'b1101;
            3'd5:    code4 = 4'b1010;
            3'd6:    code4 = 4'b0110;
            default: code4 = 4'b1110;   // primary 7, may be swapped later
         endcase
      end
   end

endmodule

// ==== source/enc_code6_mux.sv ====
// --------------------------------------
// 5b/6b sub-block selector, RD-minus codes
// Registered select, registered output
// --------------------------------------
module enc_code6_mux (
   input  logic           CLK,
   input  logic           aresetn,
   input  enc_pkg::sel5_t sel,
   output logic [5:0]     sub6
);
   import enc_pkg::*;

   sel5_t      sel_r;
   logic [5:0] code6;

   // Stage 1
   always_ff @(posedge CLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         sel_r <= '0;
      end
      else
      begin
         sel_r <= sel;
      end
   end

   // abcdei, RD-minus column of the 5b/6b table
   always_comb
   begin
      case (sel_r.edcba)
         5'd0:  code6 = 6'b100111;
         5'd1:  code6 = 6'b011101;
         5'd2:  code6 = 6'b101101;
         5'd3:  code6 = 6'b110001;
         5'd4:  code6 = 6'b110101;
         5'd5:  code6 = 6'b101001;
         5'd6:  code6 = 6'b011001;
         5'd7:  code6 = 6'b111000;
         5'd8:  code6 = 6'b111001;
         5'd9:  code6 = 6'b100101;
         5'd10: code6 = 6'b010101;
         5'd11: code6 = 6'b110100;
         5'd12: code6 = 6'b001101;
         5'd13: code6 = 6'b101100;
         5'd14: code6 = 6'b011100;
         5'd15: code6 = 6'b010111;
         5'd16: code6 = 6'b011011;
         5'd17: code6 = 6'b100011;
         5'd18: code6 = 6'b010011;
         5'd19: code6 = 6'b110010;
         5'd20: code6 = 6'b001011;
         5'd21: code6 = 6'b101010;
         5'd22: code6 = 6'b011010;
         5'd23: code6 = 6'b111010;
         5'd24: code6 = 6'b110011;
         5'd25: code6 = 6'b100110;
         5'd26: code6 = 6'b010110;
         5'd27: code6 = 6'b110110;
         5'd28: code6 = 6'b001110;
         5'd29: code6 = 6'b101110;
         5'd30: code6 = 6'b011110;
         default: code6 = 6'b101011;
      endcase
      // K28 has its own sub-block, the other K codes share the data rows
      if (sel_r.k && (sel_r.edcba == K28_IDX))
      begin
         code6 = CODE6_K28;
      end
   end

   // Stage 2
   always_ff @(posedge CLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         sub6 <= '0;
      end
      else
      begin
         sub6 <= code6;
      end
   end

endmodule

// ==== source/enc_pkg.sv ====
// --------------------------------------
// Shared types and constants for the 8b/10b
// transmit encoder, imported by RTL and checks
// --------------------------------------
package enc_pkg;

   // Cycles from tx_in sampling to tx_code
   localparam int ENC_LATENCY = 3;

   // Input character, data is HGFEDCBA
   typedef struct packed {
      logic       k;
      logic [7:0] data;
   } tx_char_t;

   // Select for the 5b/6b table
   typedef struct packed {
      logic       k;
      logic [4:0] edcba;
   } sel5_t;

   // Select for the 3b/4b table
   typedef struct packed {
      logic       k;
      logic [2:0] hgf;
   } sel3_t;

   // Running disparity
   typedef enum logic {
      RD_NEG = 1'b0,
      RD_POS = 1'b1
   } rd_t;

   // Code group, bit a is the MSB and goes out first
   typedef struct packed {
      logic [5:0] code6;
      logic [3:0] code4;
   } code10_t;

   // Index of the K28 sub-block
   localparam logic [4:0] K28_IDX = 5'd28;

   // K28 sub-block, RD-minus form
   localparam logic [5:0] CODE6_K28 = 6'b001111;

   // Balanced 6b code that still flips with disparity
   localparam logic [5:0] CODE6_D7 = 6'b111000;

   // Balanced 4b code that still flips with disparity
   localparam logic [3:0] CODE4_D3 = 4'b1100;

   // Alternate form of D.x.7
   localparam logic [3:0] CODE4_A7 = 4'b0111;

   // HGF value of x.7 characters
   localparam logic [2:0] HGF_7 = 3'd7;

endpackage
